// File: common/aes_ctrl_pkg.sv
// Cipher controller shared definitions
package aes_ctrl_pkg;

  // Datapath widths
  localparam int BLK_W  = 128;
  localparam int WORD_W = 32;

  // Identity words and unmapped read value
  localparam logic [31:0] CORE_NAME0   = 32'h6165_7331; // "aes1"
  localparam logic [31:0] CORE_NAME1   = 32'h3238_2020; // "28  "
  localparam logic [31:0] CORE_VERSION = 32'h302e_3031; // "0.01"
  localparam logic [31:0] RD_DEFAULT   = 32'h0bad_0bad;

  // 16 KB address quarters
  typedef enum logic [1:0] {
    BANK_REGS = 2'd0,
    BANK_KEY  = 2'd1,
    BANK_IP   = 2'd2,
    BANK_OP   = 2'd3
  } bank_e;

  // Register offsets within BANK_REGS
  typedef enum logic [15:0] {
    ADDR_CORE_NAME0   = 16'h0000,
    ADDR_CORE_NAME1   = 16'h0004,
    ADDR_CORE_VERSION = 16'h0008,
    ADDR_CTRL         = 16'h0010,
    ADDR_CTRL_SET     = 16'h0014,
    ADDR_CTRL_CLR     = 16'h0018,
    ADDR_STAT         = 16'h001c,
    ADDR_QUAL         = 16'h0020,
    ADDR_DREQ         = 16'h0030,
    ADDR_DREQ_SET     = 16'h0034,
    ADDR_DREQ_CLR     = 16'h0038,
    ADDR_DREQ_ACT     = 16'h003c,
    ADDR_IREQ         = 16'h0040,
    ADDR_IREQ_SET     = 16'h0044,
    ADDR_IREQ_CLR     = 16'h0048,
    ADDR_IREQ_ACT     = 16'h004c
  } reg_addr_e;

  typedef enum logic [2:0] {
    NO_KEY       = 3'd0,
    KEY_EXPAND   = 3'd1,
    KEY_READY    = 3'd2,
    BLOCK_BUSY   = 3'd3,
    RESULT_READY = 3'd4
  } seq_state_e;

  // Address phase as seen on the pins
  typedef struct packed {
    logic        ready;
    logic        sel;
    logic [1:0]  trans;
    logic [2:0]  size;
    logic        write;
    logic [15:0] addr;
  } ahb_req_t;

  // De-pipelined data phase record
  typedef struct packed {
    logic        valid;
    logic        wr;
    logic        rd;
    bank_e       bank;
    logic [13:0] addr;  // Byte offset inside the bank
    logic [3:0]  byte4; // Lane enables
  } bus_cyc_t;

  typedef struct packed {
    logic encode;    // Bit 7
    logic bypass;
    logic valid_req;
    logic keyok_req;
    logic err_req;
    logic op_req;
    logic ip_req;
    logic key_req;   // Bit 0
  } ctrl_t;

  typedef struct packed {
    logic op;
    logic ip;
    logic key;
  } req_t;

  typedef struct packed {
    logic key_ok;
    logic res_busy;
    logic res_rdy;
    logic err;
    logic key_idle;
  } seq_status_t;

endpackage

// File: rtl/ahb_capture.sv
// AHB address phase capture
`timescale 1ns/10ps

module ahb_capture
  import aes_ctrl_pkg::*;
(
  input  logic     clk,
  input  logic     rst_b,
  input  ahb_req_t req,   // Address phase inputs
  output bus_cyc_t cyc    // Registered data phase view
);

  logic       active; // Real transfer to this slave
  logic [3:0] lanes;  // Next lane enables

  assign active = req.sel & req.trans[1]; // NONSEQ or SEQ only

  // Lane decode for byte, halfword and word
  always_comb
  begin
    if (req.size[2] | req.size[1])
      lanes = 4'b1111;                              // Word or wider
    else if (req.size[0])
      lanes = req.addr[1] ? 4'b1100 : 4'b0011;      // Halfword
    else
      lanes = 4'b0001 << req.addr[1:0];             // Byte
  end

  // --------------------
  // Data phase record

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
      cyc <= '0;
    else if (req.ready)   // hready low freezes the record
    begin
      cyc.valid <= active;
      cyc.wr    <= active & req.write;
      cyc.rd    <= active & ~req.write;
      cyc.byte4 <= active ? lanes : 4'b0000;
      if (active)         // Address kept from last real transfer
      begin
        cyc.bank <= bank_e'(req.addr[15:14]);
        cyc.addr <= req.addr[13:0];
      end
    end
  end

endmodule

// File: iobuf/iobuf_reg128.sv
// 128-bit byte-addressable buffer
`timescale 1ns/10ps

module iobuf_reg128
  import aes_ctrl_pkg::*;
#(
  parameter bank_e BANK       = BANK_KEY, // Bank this buffer answers to
  parameter bit    WRITE_ONLY = 1'b0,     // Reads return zero
  parameter bit    ZERO_PAD   = 1'b0      // Word 0 lane 0 write clears the rest
)
(
  input  logic              clk,
  input  logic              rst_b,
  input  bus_cyc_t          cyc,
  input  logic [WORD_W-1:0] wdata,
  output logic [WORD_W-1:0] rdata,
  output logic [BLK_W-1:0]  blk,      // Big-endian block
  output logic              load_ack  // Last byte written
);

  logic [3:0][7:0] buf_q [4]; // Four words of four lanes
  logic            hit_wr;
  logic            hit_rd;
  logic [1:0]      widx;
  logic            pad;

  assign widx   = cyc.addr[3:2];                 // Aliased through the bank
  assign hit_wr = cyc.wr & (cyc.bank == BANK);
  assign hit_rd = cyc.rd & (cyc.bank == BANK);
  assign pad    = ZERO_PAD & hit_wr & (widx == 2'd0) & cyc.byte4[0];

  // --------------------
  // Storage

  always_ff @(posedge clk)
  begin
    for (int w = 0; w < 4; w++)
    begin
      for (int b = 0; b < 4; b++)
      begin
        if (hit_wr & cyc.byte4[b] & (widx == 2'(w)))
          buf_q[w][b] <= wdata[8*b +: 8];
        else if (pad)
          buf_q[w][b] <= 8'h00;   // Unwritten bytes of the new block
      end
    end
  end

  // Pulse after lane 3 of word 3
  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
      load_ack <= 1'b0;
    else
      load_ack <= hit_wr & (widx == 2'd3) & cyc.byte4[3];
  end

  // Lane 0 of word 0 becomes the block MSB
  for (genvar w = 0; w < 4; w++)
  begin : g_blk
    assign blk[BLK_W-1-WORD_W*w -: WORD_W] = {buf_q[w][0], buf_q[w][1],
                                             buf_q[w][2], buf_q[w][3]};
  end

  // Little-endian readback
  assign rdata = (hit_rd & ~WRITE_ONLY) ? buf_q[widx] : '0;

endmodule

// File: rtl/block_seq.sv
// Key and block sequencer
`timescale 1ns/10ps

module block_seq
  import aes_ctrl_pkg::*;
(
  input  logic        clk,
  input  logic        rst_b,
  input  bus_cyc_t    cyc,
  input  logic        key_ack,   // Key buffer full
  input  logic        ip_ack,    // Input buffer full
  input  logic        eng_done,
  output logic        start,     // Engine kick
  output seq_status_t stat
);

  seq_state_e state_q;
  seq_state_e state_d;
  logic       go;
  logic       key_wr;
  logic       op_last;
  logic       key_ok;
  logic       err_q;

  assign key_wr  = cyc.wr & (cyc.bank == BANK_KEY);
  assign op_last = cyc.rd & (cyc.bank == BANK_OP) & (cyc.addr[3:2] == 2'd3) & cyc.byte4[3];
  assign key_ok  = (state_q == KEY_READY) | (state_q == BLOCK_BUSY) |
                   (state_q == RESULT_READY);

  // --------------------
  // Next state

  always_comb
  begin
    state_d = state_q;
    go      = 1'b0;
    if (key_ack)                  // Completed key wins over a new one
    begin
      state_d = KEY_EXPAND;
      go      = 1'b1;
    end
    else if (key_wr)
      state_d = NO_KEY;           // Key being replaced
    else
    begin
      case (state_q)
        KEY_EXPAND:   if (eng_done) state_d = KEY_READY;
        KEY_READY:
          if (ip_ack)
          begin
            state_d = BLOCK_BUSY;
            go      = 1'b1;
          end
        BLOCK_BUSY:   if (eng_done) state_d = RESULT_READY;
        RESULT_READY: if (op_last)  state_d = KEY_READY;  // Result drained
        default:      ;
      endcase
    end
  end

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      state_q <= NO_KEY;
      start   <= 1'b0;
      err_q   <= 1'b0;
    end
    else
    begin
      state_q <= state_d;
      start   <= go;
      // Data access without a usable key; next key write clears
      err_q   <= (~key_ok & ((cyc.wr & (cyc.bank == BANK_IP)) |
                             (cyc.rd & (cyc.bank == BANK_OP))))
               | (err_q & ~key_wr);
    end
  end

  assign stat.key_ok   = key_ok;
  assign stat.res_busy = (state_q == BLOCK_BUSY) | ((state_q == KEY_READY) & ip_ack);
  assign stat.res_rdy  = (state_q == RESULT_READY);
  assign stat.err      = err_q;
  assign stat.key_idle = (state_q == NO_KEY) & ~key_ack;  // Nothing loaded or in flight

endmodule

// File: rtl/bypass_engine.sv
// Fixed-latency bypass engine
`timescale 1ns/10ps

module bypass_engine
  import aes_ctrl_pkg::*;
#(
  parameter int ENGINE_CYCLES = 4  // Cycles from start to done
)
(
  input  logic             clk,
  input  logic             rst_b,
  input  logic             start,
  input  logic [BLK_W-1:0] block,
  output logic             done,
  output logic [BLK_W-1:0] result
);

  localparam int CNT_W = $clog2(ENGINE_CYCLES + 1);

  logic [CNT_W-1:0] cnt_q;  // Zero when idle

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
      cnt_q <= '0;
    else if (start)
      cnt_q <= CNT_W'(ENGINE_CYCLES);   // Restart even mid-count
    else if (cnt_q != '0)
      cnt_q <= cnt_q - 1'b1;
  end

  assign done = (cnt_q == CNT_W'(1));

  // Block passes through unchanged
  always_ff @(posedge clk)
  begin
    if (done)
      result <= block;
  end

endmodule

// File: rtl/reg_bank.sv
// API register bank
`timescale 1ns/10ps

module reg_bank
  import aes_ctrl_pkg::*;
(
  input  logic              clk,
  input  logic              rst_b,
  input  bus_cyc_t          cyc,
  input  logic [WORD_W-1:0] wdata,
  input  logic              dlast_ip,   // DMA burst end, input channel
  input  logic              dlast_op,   // DMA burst end, output channel
  input  seq_status_t       stat,
  input  logic [WORD_W-1:0] key_rdata,
  input  logic [WORD_W-1:0] ip_rdata,
  input  logic [BLK_W-1:0]  result,
  output logic [WORD_W-1:0] rdata,
  output logic              drq_ip,
  output logic              drq_op,
  output logic              irq_key,
  output logic              irq_ip,
  output logic              irq_op,
  output logic              irq_error,
  output logic              irq_merged
);

  ctrl_t             ctrl_q;
  logic [WORD_W-1:0] qual_q;
  req_t              dreq_en;
  logic [3:0]        ireq_en;     // {error, op, ip, key}
  req_t              act;         // Active requests
  logic [3:0]        irq_act;
  logic [7:0]        status;
  logic [15:0]       reg_off;
  logic              reg_wr;
  logic              last_word;   // Word 3, lane 3
  logic              wlast;
  logic              rlast;
  logic [WORD_W-1:0] op_slice [4];

  assign reg_off   = {2'b00, cyc.addr[13:2], 2'b00};
  assign reg_wr    = cyc.valid & cyc.wr & (cyc.bank == BANK_REGS) & cyc.byte4[0];
  assign last_word = (cyc.addr[3:2] == 2'd3) & cyc.byte4[3];
  assign wlast     = cyc.wr & last_word & ((cyc.bank == BANK_KEY) | (cyc.bank == BANK_IP));
  assign rlast     = cyc.rd & last_word & (cyc.bank == BANK_OP);

  // --------------------
  // Register writes

  always_ff @(posedge clk or negedge rst_b)
  begin
    if (!rst_b)
    begin
      ctrl_q  <= '0;
      qual_q  <= '0;
      dreq_en <= '0;
      ireq_en <= '0;
    end
    else if (reg_wr)
    begin
      case (reg_off)
        ADDR_CTRL:     ctrl_q  <= ctrl_t'(wdata[7:0]);
        ADDR_CTRL_SET: ctrl_q  <= ctrl_t'(wdata[7:0] | ctrl_q);   // OR in
        ADDR_CTRL_CLR: ctrl_q  <= ctrl_t'(~wdata[7:0] & ctrl_q);  // AND-NOT
        ADDR_QUAL:     qual_q  <= wdata;
        ADDR_DREQ:     dreq_en <= req_t'(wdata[2:0]);
        ADDR_DREQ_SET: dreq_en <= req_t'(wdata[2:0] | dreq_en);
        ADDR_DREQ_CLR: dreq_en <= req_t'(~wdata[2:0] & dreq_en);
        ADDR_IREQ:     ireq_en <= wdata[3:0];
        ADDR_IREQ_SET: ireq_en <= wdata[3:0] | ireq_en;
        ADDR_IREQ_CLR: ireq_en <= ~wdata[3:0] & ireq_en;
        default:       ;
      endcase
    end
    // Burst end retires the DMA enable
    else if (cyc.wr & (cyc.bank == BANK_KEY) & (dlast_ip | last_word))
      dreq_en.key <= 1'b0;
    else if (cyc.wr & (cyc.bank == BANK_IP) & (dlast_ip | last_word))
      dreq_en.ip <= 1'b0;
    else if (cyc.rd & (cyc.bank == BANK_OP) & (dlast_op | last_word))
      dreq_en.op <= 1'b0;
  end

  // --------------------
  // Requests and interrupts

  assign act.key = ctrl_q.key_req & stat.key_idle;
  assign act.ip  = ctrl_q.ip_req & stat.key_ok & ~stat.res_busy & ~stat.res_rdy;
  assign act.op  = ctrl_q.op_req & stat.res_rdy;

  // Key and input share one DMA channel; drop early on last beat
  assign drq_ip = ((dreq_en.key & act.key) | (dreq_en.ip & act.ip)) & ~wlast;
  assign drq_op = dreq_en.op & act.op & ~rlast;

  assign irq_act[2:0] = act & ~dreq_en;              // Interrupt only when DMA is off
  assign irq_act[3]   = ctrl_q.err_req & stat.err;

  assign irq_key    = irq_act[0] & ireq_en[0];
  assign irq_ip     = irq_act[1] & ireq_en[1];
  assign irq_op     = irq_act[2] & ireq_en[2];
  assign irq_error  = irq_act[3] & ireq_en[3];
  assign irq_merged = irq_key | irq_ip | irq_op | irq_error;

  // Control low/high bits around sequencer flags
  assign status = {ctrl_q.encode, ctrl_q.bypass, stat.res_rdy, stat.key_ok,
                   stat.err, ctrl_q.op_req, ctrl_q.ip_req, ctrl_q.key_req};

  // Output bank words, byte reversed from the big-endian result
  for (genvar w = 0; w < 4; w++)
  begin : g_op_slice
    logic [WORD_W-1:0] be_word;
    assign be_word     = result[BLK_W-1-WORD_W*w -: WORD_W];
    assign op_slice[w] = {be_word[7:0], be_word[15:8], be_word[23:16], be_word[31:24]};
  end

  // --------------------
  // Read mux

  always_comb
  begin
    rdata = RD_DEFAULT;
    if (cyc.rd)
    begin
      case (cyc.bank)
        BANK_REGS:
          case (reg_off)
            ADDR_CORE_NAME0:   rdata = CORE_NAME0;
            ADDR_CORE_NAME1:   rdata = CORE_NAME1;
            ADDR_CORE_VERSION: rdata = CORE_VERSION;
            ADDR_CTRL:         rdata = WORD_W'(ctrl_q);
            ADDR_STAT:         rdata = WORD_W'(status);
            ADDR_QUAL:         rdata = qual_q;
            ADDR_DREQ:         rdata = WORD_W'(dreq_en);
            ADDR_DREQ_ACT:     rdata = WORD_W'(act);
            ADDR_IREQ:         rdata = WORD_W'(ireq_en);
            ADDR_IREQ_ACT:     rdata = WORD_W'(irq_act);
            default:           rdata = RD_DEFAULT;
          endcase
        BANK_KEY: rdata = key_rdata;
        BANK_IP:  rdata = ip_rdata;
        default:  rdata = op_slice[cyc.addr[3:2]];  // Aliased every 16 bytes
      endcase
    end
  end

endmodule

// File: rtl/aes_ctrl_top.sv
// Cipher accelerator controller top
`timescale 1ns/10ps

module aes_ctrl_top
  import aes_ctrl_pkg::*;
#(
  parameter int ENGINE_CYCLES = 4
)
(
  input  logic              clk,
  input  logic              rst_b,
  // AHB-Lite slave
  input  logic              hsel,
  input  logic [15:0]       haddr,
  input  logic [1:0]        htrans,
  input  logic [2:0]        hsize,
  input  logic              hwrite,
  input  logic              hready,
  input  logic [WORD_W-1:0] hwdata,
  output logic              hreadyout,
  output logic [WORD_W-1:0] hrdata,
  output logic              hresp,
  // DMA handshake
  input  logic              dlast_ipdma,
  input  logic              dlast_opdma,
  output logic              drq_ipdma,
  output logic              drq_opdma,
  // Interrupts
  output logic              irq_key,
  output logic              irq_ip,
  output logic              irq_op,
  output logic              irq_error,
  output logic              irq_merged
);

  ahb_req_t          ahb_req;
  bus_cyc_t          cyc;
  seq_status_t       stat;
  logic [WORD_W-1:0] key_rdata;
  logic [WORD_W-1:0] ip_rdata;
  logic [BLK_W-1:0]  ip_blk;
  logic [BLK_W-1:0]  result;
  logic              key_ack;
  logic              ip_ack;
  logic              eng_start;
  logic              eng_done;

  assign ahb_req = '{ready: hready, sel: hsel, trans: htrans, size: hsize,
                     write: hwrite, addr: haddr};

  assign hreadyout = 1'b1;  // Zero wait states
  assign hresp     = 1'b0;  // OKAY only

  ahb_capture u_ahb_capture (.clk(clk), .rst_b(rst_b), .req(ahb_req), .cyc(cyc));

  // Key block not consumed by the bypass engine
  iobuf_reg128 #(.BANK(BANK_KEY), .WRITE_ONLY(1'b1), .ZERO_PAD(1'b0)) u_key_buf (
    .clk(clk), .rst_b(rst_b), .cyc(cyc), .wdata(hwdata),
    .rdata(key_rdata), .blk(), .load_ack(key_ack)
  );

  iobuf_reg128 #(.BANK(BANK_IP), .WRITE_ONLY(1'b0), .ZERO_PAD(1'b1)) u_ip_buf (
    .clk(clk), .rst_b(rst_b), .cyc(cyc), .wdata(hwdata),
    .rdata(ip_rdata), .blk(ip_blk), .load_ack(ip_ack)
  );

  block_seq u_block_seq (
    .clk(clk), .rst_b(rst_b), .cyc(cyc), .key_ack(key_ack), .ip_ack(ip_ack),
    .eng_done(eng_done), .start(eng_start), .stat(stat)
  );

  bypass_engine #(.ENGINE_CYCLES(ENGINE_CYCLES)) u_bypass_engine (
    .clk(clk), .rst_b(rst_b), .start(eng_start), .block(ip_blk),
    .done(eng_done), .result(result)
  );

  reg_bank u_reg_bank (
    .clk(clk), .rst_b(rst_b), .cyc(cyc), .wdata(hwdata),
    .dlast_ip(dlast_ipdma), .dlast_op(dlast_opdma), .stat(stat),
    .key_rdata(key_rdata), .ip_rdata(ip_rdata), .result(result),
    .rdata(hrdata), .drq_ip(drq_ipdma), .drq_op(drq_opdma),
    .irq_key(irq_key), .irq_ip(irq_ip), .irq_op(irq_op),
    .irq_error(irq_error), .irq_merged(irq_merged)
  );

endmodule

// File: test/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
)
(
  output logic clk,
  output logic rst_b
);

  initial
  begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset held low for the first edges
  initial
  begin
    rst_b = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_b <= 1'b1;
  end

endmodule

// File: test/tb_aes_ctrl.sv
// Cipher controller testbench
`timescale 1ns/10ps

module tb_aes_ctrl
  import aes_ctrl_pkg::*;
();

  typedef enum logic [2:0] {
    OP_WR, OP_RD, OP_RD_CTRL, OP_RD_REQ, OP_POLL, OP_IRQ, OP_DRQ
  } step_op_e;

  typedef struct packed {
    step_op_e    op;
    logic [15:0] addr;
    logic [2:0]  size;
    logic [31:0] data;  // Write data, or poll mask
    logic [31:0] expv;
  } step_t;

  localparam logic [2:0]  SZ_B     = 3'd0;
  localparam logic [2:0]  SZ_H     = 3'd1;
  localparam logic [2:0]  SZ_W     = 3'd2;
  localparam logic [15:0] KEY_BASE = 16'h4000;
  localparam logic [15:0] IP_BASE  = 16'h8000;
  localparam logic [15:0] OP_BASE  = 16'hc000;
  localparam int POLL_LIMIT        = 64;   // Cycles per poll entry
  localparam int CYCLES_PER_STEP   = 50;

  logic clk, rst_b;
  logic hsel, hwrite, hready, hreadyout, hresp;
  logic [15:0] haddr;
  logic [1:0]  htrans;
  logic [2:0]  hsize;
  logic [31:0] hwdata, hrdata;
  logic dlast_ipdma, dlast_opdma, drq_ipdma, drq_opdma;
  logic irq_key, irq_ip, irq_op, irq_error, irq_merged;

  step_t            steps [$];
  logic [31:0]      key_w [4];
  logic [31:0]      ip_w [4];
  logic [31:0]      qual_w, byte_w, half_w;
  logic [BLK_W-1:0] blk_exp;   // Block the engine should return
  integer           seed;
  int               cycle_cnt = 0;
  int               limit_cycles;

  tb_clock_gen u_clock_gen (.clk(clk), .rst_b(rst_b));

  aes_ctrl_top u_aes_ctrl_top (
    .clk(clk), .rst_b(rst_b), .hsel(hsel), .haddr(haddr), .htrans(htrans),
    .hsize(hsize), .hwrite(hwrite), .hready(hready), .hwdata(hwdata),
    .hreadyout(hreadyout), .hrdata(hrdata), .hresp(hresp),
    .dlast_ipdma(dlast_ipdma), .dlast_opdma(dlast_opdma),
    .drq_ipdma(drq_ipdma), .drq_opdma(drq_opdma), .irq_key(irq_key),
    .irq_ip(irq_ip), .irq_op(irq_op), .irq_error(irq_error), .irq_merged(irq_merged)
  );

  // --------------------
  // Reference model

  function automatic logic [31:0] byte_rev(input logic [31:0] x);
    return {x[7:0], x[15:8], x[23:16], x[31:24]};
  endfunction

  // Lane 0 of bus word 0 lands in the block MSB
  function automatic logic [BLK_W-1:0] pack_block(input logic [31:0] w0, w1, w2, w3);
    return {byte_rev(w0), byte_rev(w1), byte_rev(w2), byte_rev(w3)};
  endfunction

  // Output bank word w is slice w of the block, byte reversed
  function automatic logic [31:0] out_word(input logic [BLK_W-1:0] blk, input int w);
    return byte_rev(blk[BLK_W-1-WORD_W*w -: WORD_W]);
  endfunction

  // --------------------
  // Failure and compare tasks

  task automatic end_with_failure();
    $display("Test FAILED");
    $fatal(1, "Simulation stopped on first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] expv);
    if (got !== expv)
    begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, expv);
      end_with_failure();
    end
  endtask

  task automatic check_ctrl(input string name, input ctrl_t got, input ctrl_t expv);
    if (got !== expv)
    begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, got, expv);
      end_with_failure();
    end
  endtask

  task automatic check_req(input string name, input req_t got, input req_t expv);
    if (got !== expv)
    begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, expv);
      end_with_failure();
    end
  endtask

  task automatic check_irq(input string name, input logic [4:0] got, input logic [4:0] expv);
    if (got !== expv)
    begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, expv);
      end_with_failure();
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic expv);
    if (got !== expv)
    begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, got, expv);
      end_with_failure();
    end
  endtask

  // --------------------
  // AHB transfers

  // Address phase, then data phase; one idle cycle follows
  task automatic ahb_write(input logic [15:0] addr, input logic [2:0] size, input logic [31:0] data);
    @(posedge clk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;   // NONSEQ
    hsize  <= size;
    hwrite <= 1'b1;
    @(posedge clk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwrite <= 1'b0;
    hwdata <= data;    // Held through the commit edge
    @(negedge clk);
    check_bit("hreadyout", hreadyout, 1'b1);  // Zero wait states
    check_bit("hresp", hresp, 1'b0);          // OKAY
  endtask

  task automatic ahb_read(input logic [15:0] addr, input logic [2:0] size, output logic [31:0] data);
    @(posedge clk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= 2'b10;
    hsize  <= size;
    hwrite <= 1'b0;
    @(posedge clk);
    hsel   <= 1'b0;
    htrans <= 2'b00;
    @(negedge clk);    // Mid data phase
    check_bit("hreadyout", hreadyout, 1'b1);
    check_bit("hresp", hresp, 1'b0);
    data = hrdata;
  endtask

  task automatic poll_status(input logic [15:0] addr, input logic [31:0] mask, input logic [31:0] expv);
    logic [31:0] rd;
    int          start_cnt;
    logic        hit;
    logic        late;
    start_cnt = cycle_cnt;
    hit       = 1'b0;
    late      = 1'b0;
    while (!hit && !late)
    begin
      ahb_read(addr, SZ_W, rd);
      if ((rd & mask) == expv)
        hit = 1'b1;
      else if (cycle_cnt - start_cnt > POLL_LIMIT)
        late = 1'b1;
    end
    if (late)
    begin
      $display("Register %h never reached %h under mask %h within %0d cycles",
               addr, expv, mask, POLL_LIMIT);
      end_with_failure();
    end
  endtask

  // --------------------
  // Stimulus table

  task automatic add_step(input step_op_e op, input logic [15:0] addr, input logic [2:0] size,
                          input logic [31:0] data, input logic [31:0] expv);
    step_t s;
    s.op   = op;
    s.addr = addr;
    s.size = size;
    s.data = data;
    s.expv = expv;
    steps.push_back(s);
  endtask

  task automatic build_table();
    for (int i = 0; i < 4; i++) key_w[i] = $random(seed);
    for (int i = 0; i < 4; i++) ip_w[i] = $random(seed);
    qual_w  = $random(seed);
    byte_w  = $random(seed);
    half_w  = $random(seed);
    blk_exp = pack_block(ip_w[0], ip_w[1], ip_w[2], ip_w[3]);  // Bypass returns it unchanged
    // Identity and unmapped
    add_step(OP_RD, ADDR_CORE_NAME0, SZ_W, 0, "aes1");
    add_step(OP_RD, ADDR_CORE_NAME1, SZ_W, 0, "28  ");
    add_step(OP_RD, ADDR_CORE_VERSION, SZ_W, 0, "0.01");
    add_step(OP_RD, 16'h000c, SZ_W, 0, 32'h0bad_0bad);
    add_step(OP_RD, 16'h0050, SZ_W, 0, 32'h0bad_0bad);
    // Write, set and clear aliases
    add_step(OP_WR, ADDR_CTRL, SZ_W, 32'ha5, 0);
    add_step(OP_RD_CTRL, ADDR_CTRL, SZ_W, 0, 32'ha5);
    add_step(OP_WR, ADDR_CTRL_SET, SZ_W, 32'h0a, 0);
    add_step(OP_RD_CTRL, ADDR_CTRL, SZ_W, 0, 32'haf);
    add_step(OP_WR, ADDR_CTRL_CLR, SZ_W, 32'h21, 0);
    add_step(OP_RD_CTRL, ADDR_CTRL, SZ_W, 0, 32'h8e);
    add_step(OP_WR, ADDR_CTRL, SZ_W, 0, 0);
    add_step(OP_WR, ADDR_DREQ, SZ_W, 32'h5, 0);
    add_step(OP_RD_REQ, ADDR_DREQ, SZ_W, 0, 32'h5);
    add_step(OP_WR, ADDR_DREQ_SET, SZ_W, 32'h2, 0);
    add_step(OP_RD_REQ, ADDR_DREQ, SZ_W, 0, 32'h7);
    add_step(OP_WR, ADDR_DREQ_CLR, SZ_W, 32'h5, 0);
    add_step(OP_RD_REQ, ADDR_DREQ, SZ_W, 0, 32'h2);
    add_step(OP_WR, ADDR_DREQ, SZ_W, 0, 0);
    add_step(OP_WR, ADDR_IREQ, SZ_W, 32'h9, 0);
    add_step(OP_RD, ADDR_IREQ, SZ_W, 0, 32'h9);
    add_step(OP_WR, ADDR_IREQ_SET, SZ_W, 32'h6, 0);
    add_step(OP_RD, ADDR_IREQ, SZ_W, 0, 32'hf);
    add_step(OP_WR, ADDR_IREQ_CLR, SZ_W, 32'h3, 0);
    add_step(OP_RD, ADDR_IREQ, SZ_W, 0, 32'hc);
    add_step(OP_WR, ADDR_IREQ, SZ_W, 0, 0);
    add_step(OP_WR, ADDR_QUAL, SZ_W, qual_w, 0);
    add_step(OP_RD, ADDR_QUAL, SZ_W, 0, qual_w);
    // Input access with no key sets err
    add_step(OP_WR, ADDR_CTRL, SZ_W, 32'h08, 0);                 // err_req
    add_step(OP_WR, ADDR_IREQ, SZ_W, 32'h8, 0);
    add_step(OP_WR, IP_BASE + 16'h4, SZ_W, ip_w[1], 0);
    add_step(OP_IRQ, 0, SZ_W, 0, 32'b11000);                    // {merged, error, op, ip, key}
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 32'h08);
    add_step(OP_WR, KEY_BASE, SZ_W, key_w[0], 0);                // Key write clears err
    add_step(OP_IRQ, 0, SZ_W, 0, 0);
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 0);
    // Key request, by interrupt and by DMA
    add_step(OP_WR, ADDR_CTRL, SZ_W, 32'h01, 0);
    add_step(OP_WR, ADDR_IREQ, SZ_W, 32'h1, 0);
    add_step(OP_IRQ, 0, SZ_W, 0, 32'b10001);
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 32'h01);
    add_step(OP_RD_REQ, ADDR_DREQ_ACT, SZ_W, 0, 32'h1);
    add_step(OP_WR, ADDR_DREQ, SZ_W, 32'h1, 0);
    add_step(OP_DRQ, 0, SZ_W, 0, 32'h2);                         // Key rides the input pin
    add_step(OP_IRQ, 0, SZ_W, 0, 0);
    add_step(OP_WR, ADDR_DREQ_CLR, SZ_W, 32'h1, 0);
    add_step(OP_DRQ, 0, SZ_W, 0, 0);
    add_step(OP_IRQ, 0, SZ_W, 0, 32'b10001);
    for (int i = 0; i < 4; i++) add_step(OP_WR, 16'(4 * i) + KEY_BASE, SZ_W, key_w[i], 0);
    add_step(OP_IRQ, 0, SZ_W, 0, 0);
    add_step(OP_POLL, ADDR_STAT, SZ_W, 32'h10, 32'h10);          // keyok
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 32'h11);
    add_step(OP_WR, ADDR_CTRL, SZ_W, 0, 0);
    add_step(OP_WR, ADDR_IREQ, SZ_W, 0, 0);
    // Lane writes and zero padding
    add_step(OP_WR, IP_BASE, SZ_B, byte_w, 0);
    add_step(OP_RD, IP_BASE, SZ_W, 0, {24'h0, byte_w[7:0]});
    for (int i = 1; i < 4; i++) add_step(OP_RD, 16'(4 * i) + IP_BASE, SZ_W, 0, 0);
    add_step(OP_WR, IP_BASE + 16'h2, SZ_H, half_w, 0);           // Upper halfword, no pad
    add_step(OP_RD, IP_BASE, SZ_W, 0, {half_w[31:16], 8'h00, byte_w[7:0]});
    add_step(OP_RD, KEY_BASE, SZ_W, 0, 0);
    add_step(OP_RD, KEY_BASE + 16'hc, SZ_W, 0, 0);
    for (int i = 0; i < 4; i++) add_step(OP_WR, 16'(4 * i) + IP_BASE, SZ_W, ip_w[i], 0);
    for (int i = 0; i < 4; i++) add_step(OP_RD, 16'(4 * i) + IP_BASE, SZ_W, 0, ip_w[i]);
    // Result drained over output DMA
    add_step(OP_WR, ADDR_CTRL, SZ_W, 32'h04, 0);                 // op_req
    add_step(OP_WR, ADDR_DREQ, SZ_W, 32'h4, 0);
    add_step(OP_POLL, ADDR_STAT, SZ_W, 32'h20, 32'h20);          // valid
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 32'h34);
    add_step(OP_DRQ, 0, SZ_W, 0, 32'h4);
    for (int i = 0; i < 4; i++)
      add_step(OP_RD, 16'(4 * i) + OP_BASE, SZ_W, 0, out_word(blk_exp, i));
    add_step(OP_DRQ, 0, SZ_W, 0, 0);
    add_step(OP_RD_REQ, ADDR_DREQ, SZ_W, 0, 0);                  // Enable retired on last beat
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 32'h14);
    add_step(OP_WR, ADDR_CTRL, SZ_W, 0, 0);
    add_step(OP_RD, ADDR_STAT, SZ_W, 0, 32'h10);
  endtask

  task automatic run_step(input step_t s);
    logic [31:0] rd;
    req_t        pins;
    string       name;
    name = $sformatf("hrdata[%h]", s.addr);
    case (s.op)
      OP_WR:   ahb_write(s.addr, s.size, s.data);
      OP_POLL: poll_status(s.addr, s.data, s.expv);
      OP_RD:
      begin
        ahb_read(s.addr, s.size, rd);
        check_word(name, rd, s.expv);
      end
      OP_RD_CTRL:
      begin
        ahb_read(s.addr, s.size, rd);
        check_ctrl(name, ctrl_t'(rd[7:0]), ctrl_t'(s.expv[7:0]));
      end
      OP_RD_REQ:
      begin
        ahb_read(s.addr, s.size, rd);
        check_req(name, req_t'(rd[2:0]), req_t'(s.expv[2:0]));
      end
      OP_IRQ:
      begin
        @(negedge clk);
        check_irq("irq {merged,error,op,ip,key}",
                  {irq_merged, irq_error, irq_op, irq_ip, irq_key}, s.expv[4:0]);
      end
      default:   // OP_DRQ
      begin
        @(negedge clk);
        pins.op  = drq_opdma;
        pins.ip  = drq_ipdma;
        pins.key = 1'b0;   // Key shares drq_ipdma
        check_req("drq {op,ip,key}", pins, req_t'(s.expv[2:0]));
      end
    endcase
  endtask

  // --------------------
  // Watchdog and main sequence

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt > limit_cycles)
    begin
      $display("Run did not finish within %0d cycles", limit_cycles);
      end_with_failure();
    end
  end

  initial
  begin
    hsel        <= 1'b0;
    haddr       <= '0;
    htrans      <= 2'b00;
    hsize       <= SZ_W;
    hwrite      <= 1'b0;
    hready      <= 1'b1;   // No other slave stalls the bus
    hwdata      <= '0;
    dlast_ipdma <= 1'b0;
    dlast_opdma <= 1'b0;
    seed         = 56;
    build_table();
    limit_cycles = steps.size() * CYCLES_PER_STEP;
    wait (rst_b === 1'b1);
    foreach (steps[i])
    begin
      run_step(steps[i]);
    end
    $display("Test OK");
    $finish;
  end

endmodule

// File: sim.f
common/aes_ctrl_pkg.sv
rtl/ahb_capture.sv
iobuf/iobuf_reg128.sv
rtl/block_seq.sv
rtl/bypass_engine.sv
rtl/reg_bank.sv
rtl/aes_ctrl_top.sv
test/tb_clock_gen.sv
test/tb_aes_ctrl.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_aes_ctrl
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
